//--- design/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  rename_pkg::alloc_cnt_t                             alloc_cnt,
    output logic                                               alloc_ok,
    output rename_pkg::preg_t [rename_pkg::FETCH_WIDTH-1:0]    alloc_preg,
    input  logic              [rename_pkg::COMMIT_WIDTH-1:0]   release_en,
    input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]   release_preg,
    output rename_pkg::free_cnt_t                              free_count
);
    import rename_pkg::*;

    preg_t                        fifo_q [FREE_DEPTH];
    free_ptr_t                    head_q;
    free_ptr_t                    tail_q;
    free_cnt_t                    count_q;
    alloc_cnt_t                   pop_cnt;
    free_cnt_t                    push_cnt;
    free_ptr_t [COMMIT_WIDTH-1:0] push_ofs;

    assign alloc_ok   = free_cnt_t'(alloc_cnt) <= count_q;
    assign pop_cnt    = alloc_ok ? alloc_cnt : '0;
    assign free_count = count_q;

    // the head entries are offered every cycle and taken only on a grant.
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            alloc_preg[k] = fifo_q[head_q + free_ptr_t'(k)];
        end
    end

    // released registers go into consecutive slots behind the tail in lane order.
    always_comb begin
        push_cnt = '0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            push_ofs[k] = free_ptr_t'(push_cnt);
            push_cnt    = push_cnt + free_cnt_t'(release_en[k]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < FREE_DEPTH; k++) begin
                fifo_q[k] <= preg_t'(ARCH_REGS + k);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= free_cnt_t'(FREE_DEPTH);
        end else begin
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                if (release_en[k]) begin
                    fifo_q[tail_q + push_ofs[k]] <= release_preg[k];
                end
            end
            head_q  <= head_q + free_ptr_t'(pop_cnt);
            tail_q  <= tail_q + free_ptr_t'(push_cnt);
            count_q <= count_q + push_cnt - free_cnt_t'(pop_cnt);
        end
    end

    short_pop_blocked: assert property (@(posedge clk) disable iff (!arst_n)
        (free_cnt_t'(alloc_cnt) > count_q) |=> (head_q == $past(head_q)))
        else $error("free_list: pop of %0d with %0d entries", $past(alloc_cnt), $past(count_q));

    no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (int'(count_q) + int'(push_cnt) - int'(pop_cnt)) <= FREE_DEPTH)
        else $error("free_list: push of %0d overflows %0d entries", push_cnt, count_q);

endmodule

//--- design/rat_bank.sv
`timescale 1ns/1ps

module rat_bank #(
    parameter int RD_PORTS = rename_pkg::FETCH_WIDTH,
    parameter int WR_PORTS = rename_pkg::FETCH_WIDTH
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  rename_pkg::vreg_t   [RD_PORTS-1:0] rd_addr,
    output rename_pkg::preg_t   [RD_PORTS-1:0] rd_data,
    input  rename_pkg::rat_wr_t [WR_PORTS-1:0] wr
);
    import rename_pkg::*;

    preg_t map_q [ARCH_REGS];

    // reads see the contents from before this cycle's writes.
    always_comb begin
        for (int i = 0; i < RD_PORTS; i++) begin
            rd_data[i] = map_q[rd_addr[i]];
        end
    end

    // later ports overwrite earlier ones, so the highest lane wins a shared address.
    // x0 is never written and keeps mapping to p0.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_q[r] <= preg_t'(r);
            end
        end else begin
            for (int p = 0; p < WR_PORTS; p++) begin
                if (wr[p].we && (wr[p].waddr != '0)) begin
                    map_q[wr[p].waddr] <= wr[p].wdata;
                end
            end
        end
    end

endmodule

//--- design/rename_pkg.sv
package rename_pkg;

    //////////////////////////////
    // widths and sizes.
    //////////////////////////////
    localparam int FETCH_WIDTH     = 2;
    localparam int COMMIT_WIDTH    = 2;
    localparam int ARCH_REGS       = 32;
    localparam int VREG_WIDTH      = 5;
    localparam int PREG_NUM        = 64;
    localparam int PREG_WIDTH      = 6;
    localparam int FREE_DEPTH      = PREG_NUM - ARCH_REGS;
    localparam int FREE_PTR_WIDTH  = $clog2(FREE_DEPTH);
    localparam int FREE_CNT_WIDTH  = $clog2(FREE_DEPTH + 1);
    localparam int ALLOC_CNT_WIDTH = $clog2(FETCH_WIDTH + 1);
    localparam int LANE_IDX_WIDTH  = (COMMIT_WIDTH > 1) ? $clog2(COMMIT_WIDTH) : 1;

    typedef logic [VREG_WIDTH-1:0]      vreg_t;
    typedef logic [PREG_WIDTH-1:0]      preg_t;
    typedef logic [LANE_IDX_WIDTH-1:0]  lane_idx_t;
    typedef logic [ALLOC_CNT_WIDTH-1:0] alloc_cnt_t;
    typedef logic [FREE_CNT_WIDTH-1:0]  free_cnt_t;
    typedef logic [FREE_PTR_WIDTH-1:0]  free_ptr_t;

    //////////////////////////////
    // buses.
    //////////////////////////////
    typedef struct packed {
        logic  [FETCH_WIDTH-1:0] valid;
        vreg_t [FETCH_WIDTH-1:0] vrs1;
        vreg_t [FETCH_WIDTH-1:0] vrs2;
        logic  [FETCH_WIDTH-1:0] we;
        vreg_t [FETCH_WIDTH-1:0] vrd;
    } rename_req_t;

    typedef struct packed {
        preg_t [FETCH_WIDTH-1:0] prs1;
        preg_t [FETCH_WIDTH-1:0] prs2;
        preg_t [FETCH_WIDTH-1:0] prd;
    } rename_rsp_t;

    typedef struct packed {
        logic  en;
        logic  we;
        vreg_t vrd;
        preg_t prd;
    } commit_lane_t;

    typedef commit_lane_t [COMMIT_WIDTH-1:0] commit_bus_t;

    // walk lanes line up with the rename write ports of the speculative tables.
    typedef struct packed {
        logic                     walk;
        logic  [COMMIT_WIDTH-1:0] we;
        vreg_t [COMMIT_WIDTH-1:0] vrd;
        preg_t [COMMIT_WIDTH-1:0] prd;
    } walk_bus_t;

    typedef struct packed {
        logic  we;
        vreg_t waddr;
        preg_t wdata;
    } rat_wr_t;

    typedef enum logic {
        IDLE,
        HOLD
    } rename_state_e;

endpackage

//--- design/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  rename_pkg::rename_req_t                              rename_req,
    input  logic                                                 req,
    output logic                                                 ack,
    output rename_pkg::rename_rsp_t                              rename_rsp,
    output rename_pkg::vreg_t   [rename_pkg::FETCH_WIDTH-1:0]    rat_vrs1,
    output rename_pkg::vreg_t   [rename_pkg::FETCH_WIDTH-1:0]    rat_vrs2,
    input  rename_pkg::preg_t   [rename_pkg::FETCH_WIDTH-1:0]    rat_prs1,
    input  rename_pkg::preg_t   [rename_pkg::FETCH_WIDTH-1:0]    rat_prs2,
    output rename_pkg::rat_wr_t [rename_pkg::FETCH_WIDTH-1:0]    rename_wr,
    output rename_pkg::alloc_cnt_t                               alloc_cnt,
    input  logic                                                 alloc_ok,
    input  rename_pkg::preg_t   [rename_pkg::FETCH_WIDTH-1:0]    alloc_preg,
    input  logic                                                 walk_active
);
    import rename_pkg::*;

    rename_state_e                state_q;
    rename_state_e                state_d;
    rename_rsp_t                  rsp_d;
    rename_rsp_t                  rsp_q;
    logic       [FETCH_WIDTH-1:0] need;
    alloc_cnt_t [FETCH_WIDTH-1:0] slot;
    alloc_cnt_t                   need_cnt;
    preg_t      [FETCH_WIDTH-1:0] new_prd;
    logic                         try_alloc;
    logic                         grant;

    assign rat_vrs1 = rename_req.vrs1;
    assign rat_vrs2 = rename_req.vrs2;

    //////////////////////////////
    // destination allocation.
    //////////////////////////////
    // each lane with a real destination takes the next free-list slot in lane order.
    always_comb begin
        need_cnt = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            need[i]    = rename_req.valid[i] & rename_req.we[i] & (rename_req.vrd[i] != '0);
            slot[i]    = need_cnt;
            new_prd[i] = alloc_preg[slot[i]];
            need_cnt   = need_cnt + alloc_cnt_t'(need[i]);
        end
    end

    // the tables still hold pre-group mappings, so older lanes in the group are bypassed.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rsp_d.prs1[i] = rat_prs1[i];
            rsp_d.prs2[i] = rat_prs2[i];
            for (int j = 0; j < i; j++) begin
                if (need[j] && (rename_req.vrd[j] == rename_req.vrs1[i])) begin
                    rsp_d.prs1[i] = new_prd[j];
                end
                if (need[j] && (rename_req.vrd[j] == rename_req.vrs2[i])) begin
                    rsp_d.prs2[i] = new_prd[j];
                end
            end
            if (rename_req.vrs1[i] == '0) begin
                rsp_d.prs1[i] = '0;
            end
            if (rename_req.vrs2[i] == '0) begin
                rsp_d.prs2[i] = '0;
            end
            rsp_d.prd[i] = need[i] ? new_prd[i] : '0;
        end
    end

    //////////////////////////////
    // handshake.
    //////////////////////////////
    assign try_alloc = (state_q == IDLE) && req && !walk_active;
    assign alloc_cnt = try_alloc ? need_cnt : '0;
    assign grant     = try_alloc && alloc_ok;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rename_wr[i].we    = grant & need[i];
            rename_wr[i].waddr = rename_req.vrd[i];
            rename_wr[i].wdata = new_prd[i];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (grant) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                if (!req) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            rsp_q <= rsp_d;
        end
    end

    assign ack        = (state_q == HOLD);
    assign rename_rsp = rsp_q;

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req && !walk_active))
        else $error("rename_stage: ack rose without req or during walk");

endmodule

//--- design/rename_subsystem.sv
`timescale 1ns/1ps

module rename_subsystem (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  rename_pkg::rename_req_t                              rename_req,
    input  logic                                                 req,
    output logic                                                 ack,
    output rename_pkg::rename_rsp_t                              rename_rsp,
    input  rename_pkg::commit_bus_t                              commit,
    input  rename_pkg::walk_bus_t                                walk,
    output rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]     old_prd,
    output rename_pkg::free_cnt_t                                free_count
);
    import rename_pkg::*;

    vreg_t      [FETCH_WIDTH-1:0]  rat_vrs1;
    vreg_t      [FETCH_WIDTH-1:0]  rat_vrs2;
    preg_t      [FETCH_WIDTH-1:0]  rat_prs1;
    preg_t      [FETCH_WIDTH-1:0]  rat_prs2;
    rat_wr_t    [FETCH_WIDTH-1:0]  rename_wr;
    alloc_cnt_t                    alloc_cnt;
    logic                          alloc_ok;
    preg_t      [FETCH_WIDTH-1:0]  alloc_preg;
    logic       [COMMIT_WIDTH-1:0] release_en;

    // every committed destination hands its previous mapping back.
    always_comb begin
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            release_en[k] = commit[k].en & commit[k].we & (commit[k].vrd != '0);
        end
    end

    rename_stage rename_stage_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rename_req  (rename_req),
        .req         (req),
        .ack         (ack),
        .rename_rsp  (rename_rsp),
        .rat_vrs1    (rat_vrs1),
        .rat_vrs2    (rat_vrs2),
        .rat_prs1    (rat_prs1),
        .rat_prs2    (rat_prs2),
        .rename_wr   (rename_wr),
        .alloc_cnt   (alloc_cnt),
        .alloc_ok    (alloc_ok),
        .alloc_preg  (alloc_preg),
        .walk_active (walk.walk)
    );

    rename_table rename_table_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .vrs1      (rat_vrs1),
        .vrs2      (rat_vrs2),
        .prs1      (rat_prs1),
        .prs2      (rat_prs2),
        .rename_wr (rename_wr),
        .walk      (walk),
        .commit    (commit),
        .old_prd   (old_prd)
    );

    free_list free_list_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .alloc_cnt    (alloc_cnt),
        .alloc_ok     (alloc_ok),
        .alloc_preg   (alloc_preg),
        .release_en   (release_en),
        .release_preg (old_prd),
        .free_count   (free_count)
    );

endmodule

//--- design/rename_table.sv
`timescale 1ns/1ps

module rename_table (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  rename_pkg::vreg_t   [rename_pkg::FETCH_WIDTH-1:0]    vrs1,
    input  rename_pkg::vreg_t   [rename_pkg::FETCH_WIDTH-1:0]    vrs2,
    output rename_pkg::preg_t   [rename_pkg::FETCH_WIDTH-1:0]    prs1,
    output rename_pkg::preg_t   [rename_pkg::FETCH_WIDTH-1:0]    prs2,
    input  rename_pkg::rat_wr_t [rename_pkg::FETCH_WIDTH-1:0]    rename_wr,
    input  rename_pkg::walk_bus_t                                walk,
    input  rename_pkg::commit_bus_t                              commit,
    output rename_pkg::preg_t   [rename_pkg::COMMIT_WIDTH-1:0]   old_prd
);
    import rename_pkg::*;

    rat_wr_t   [FETCH_WIDTH-1:0]  spec_wr;
    rat_wr_t   [COMMIT_WIDTH-1:0] commit_wr;
    vreg_t     [COMMIT_WIDTH-1:0] commit_vrd;
    preg_t     [COMMIT_WIDTH-1:0] commit_map;
    logic      [COMMIT_WIDTH-1:0] cancel;
    lane_idx_t [COMMIT_WIDTH-1:0] replace_idx;

    // recovery owns the speculative write ports while walk is up.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (walk.walk) begin
                spec_wr[i].we    = walk.we[i];
                spec_wr[i].waddr = walk.vrd[i];
                spec_wr[i].wdata = walk.prd[i];
            end else begin
                spec_wr[i] = rename_wr[i];
            end
        end
    end

    rat_bank #(.RD_PORTS(FETCH_WIDTH), .WR_PORTS(FETCH_WIDTH)) spec_rs1_rat (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (vrs1),
        .rd_data (prs1),
        .wr      (spec_wr)
    );

    rat_bank #(.RD_PORTS(FETCH_WIDTH), .WR_PORTS(FETCH_WIDTH)) spec_rs2_rat (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (vrs2),
        .rd_data (prs2),
        .wr      (spec_wr)
    );

    //////////////////////////////
    // committed table.
    //////////////////////////////
    waw_resolver waw_resolver_inst (
        .commit      (commit),
        .cancel      (cancel),
        .replace_idx (replace_idx)
    );

    // only the last writer of each register in the group reaches the table.
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_vrd[i]      = commit[i].vrd;
            commit_wr[i].we    = commit[i].en & commit[i].we & ~cancel[i];
            commit_wr[i].waddr = commit[i].vrd;
            commit_wr[i].wdata = commit[i].prd;
        end
    end

    rat_bank #(.RD_PORTS(COMMIT_WIDTH), .WR_PORTS(COMMIT_WIDTH)) commit_rat (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_addr (commit_vrd),
        .rd_data (commit_map),
        .wr      (commit_wr)
    );

    // a lane that replaces an earlier same-register lane frees that lane's prd instead.
    always_comb begin
        for (int j = 0; j < COMMIT_WIDTH; j++) begin
            old_prd[j] = commit_map[j];
            for (int i = 0; i < j; i++) begin
                if (cancel[i] && (int'(replace_idx[i]) == j)) begin
                    old_prd[j] = commit[i].prd;
                end
            end
        end
    end

endmodule

//--- design/waw_resolver.sv
`timescale 1ns/1ps

module waw_resolver (
    input  rename_pkg::commit_bus_t                              commit,
    output logic [rename_pkg::COMMIT_WIDTH-1:0]                  cancel,
    output rename_pkg::lane_idx_t [rename_pkg::COMMIT_WIDTH-1:0] replace_idx
);
    import rename_pkg::*;

    logic [COMMIT_WIDTH-1:0]                   commit_we;
    logic [COMMIT_WIDTH-1:0][COMMIT_WIDTH-1:0] waw;

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_we[i] = commit[i].en & commit[i].we & (commit[i].vrd != '0);
        end

        // only pairs with j above i are marked, so cancel means a later lane overwrites.
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            for (int j = 0; j < COMMIT_WIDTH; j++) begin
                waw[i][j] = (j > i) && commit_we[i] && commit_we[j]
                            && (commit[i].vrd == commit[j].vrd);
            end
            cancel[i] = |waw[i];

            // scan downward so the earliest later lane is the one kept.
            replace_idx[i] = '0;
            for (int j = COMMIT_WIDTH - 1; j > i; j--) begin
                if (waw[i][j]) begin
                    replace_idx[i] = lane_idx_t'(j);
                end
            end
        end
    end

    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : g_chk
        replace_after_lane: assert final (!cancel[i] || (int'(replace_idx[i]) > i))
            else $error("waw_resolver: lane %0d replaced by lane %0d", i, replace_idx[i]);
    end

endmodule

//--- files.f
design/rename_pkg.sv
design/rat_bank.sv
design/waw_resolver.sv
design/rename_table.sv
design/free_list.sv
design/rename_stage.sv
design/rename_subsystem.sv
tests/tb_clock.sv
tests/rename_tb.sv

//--- tests/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = 60 * NUM_TESTS + 200;
    localparam int HS_LIMIT        = 40;
    localparam int RANDOM_GROUPS   = 24;

    logic                     clk;
    logic                     arst_n;
    rename_req_t              rename_req;
    logic                     req;
    logic                     ack;
    rename_rsp_t              rename_rsp;
    commit_bus_t              commit;
    walk_bus_t                walk;
    preg_t [COMMIT_WIDTH-1:0] old_prd;
    free_cnt_t                free_count;

    // reference model of the speculative map, the committed map and the free FIFO.
    preg_t        spec_map [ARCH_REGS];
    preg_t        commit_map [ARCH_REGS];
    preg_t        free_q [$];
    commit_lane_t in_flight [$];

    rename_rsp_t              exp_rsp       = '0;
    preg_t [COMMIT_WIDTH-1:0] exp_old       = '0;
    logic                     expect_no_ack = 1'b0;
    int                       seed          = 80442;
    int                       errors        = 0;
    int                       passed        = 0;
    int                       failed        = 0;

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) tb_clock_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rename_subsystem rename_subsystem_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .rename_req (rename_req),
        .req        (req),
        .ack        (ack),
        .rename_rsp (rename_rsp),
        .commit     (commit),
        .walk       (walk),
        .old_prd    (old_prd),
        .free_count (free_count)
    );

    //////////////////////////////
    // checks.
    //////////////////////////////
    rsp_check: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> (rename_rsp == exp_rsp))
        else begin
            errors++;
            $display("error rename_rsp got %h expected %h", $sampled(rename_rsp), exp_rsp);
        end

    ack_held_low: assert property (@(posedge clk) disable iff (!arst_n)
        expect_no_ack |-> !ack)
        else begin
            errors++;
            $display("error ack got %h expected %h while blocked", 1'b1, 1'b0);
        end

    ack_falls: assert property (@(posedge clk) disable iff (!arst_n)
        (ack && !req) |=> !ack)
        else begin
            errors++;
            $display("error ack got %h expected %h after req fell", 1'b1, 1'b0);
        end

    for (genvar k = 0; k < COMMIT_WIDTH; k++) begin : g_old
        old_prd_check: assert property (@(posedge clk) disable iff (!arst_n)
            (commit[k].en && commit[k].we) |-> (old_prd[k] == exp_old[k]))
            else begin
                errors++;
                $display("error old_prd[%0d] got %h expected %h",
                         k, $sampled(old_prd[k]), $sampled(exp_old[k]));
            end
    end

    //////////////////////////////
    // model and stimulus.
    //////////////////////////////
    function automatic rename_req_t make_group(input vreg_t a1, input vreg_t a2, input vreg_t ad,
                                               input vreg_t b1, input vreg_t b2, input vreg_t bd);
        rename_req_t g;
        g.valid   = '1;
        g.we      = '1;
        g.vrs1[0] = a1;
        g.vrs2[0] = a2;
        g.vrd[0]  = ad;
        g.vrs1[1] = b1;
        g.vrs2[1] = b2;
        g.vrd[1]  = bd;
        return g;
    endfunction

    function automatic rename_req_t random_group();
        rename_req_t g;
        g.valid = '1;
        g.we    = '1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            g.vrs1[i] = vreg_t'($random(seed));
            g.vrs2[i] = vreg_t'($random(seed));
            g.vrd[i]  = vreg_t'($random(seed));
        end
        return g;
    endfunction

    function automatic int count_needs(input rename_req_t g);
        int n;
        n = 0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (g.valid[i] && g.we[i] && (g.vrd[i] != '0)) begin
                n++;
            end
        end
        return n;
    endfunction

    // lanes are renamed one after another, so a later lane sees an earlier lane's new mapping.
    function automatic void predict_group(input rename_req_t g);
        commit_lane_t ent;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            exp_rsp.prs1[i] = (g.vrs1[i] == '0) ? '0 : spec_map[g.vrs1[i]];
            exp_rsp.prs2[i] = (g.vrs2[i] == '0) ? '0 : spec_map[g.vrs2[i]];
            exp_rsp.prd[i]  = '0;
            if (g.valid[i] && g.we[i] && (g.vrd[i] != '0)) begin
                exp_rsp.prd[i]      = free_q.pop_front();
                spec_map[g.vrd[i]] = exp_rsp.prd[i];
                ent.en              = 1'b1;
                ent.we              = 1'b1;
                ent.vrd             = g.vrd[i];
                ent.prd             = exp_rsp.prd[i];
                in_flight.push_back(ent);
            end
        end
    endfunction

    task automatic raise_req(input rename_req_t g);
        @(posedge clk);
        rename_req <= g;
        req        <= 1'b1;
    endtask

    task automatic finish_group();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ack && (n < HS_LIMIT));
        if (!ack) begin
            errors++;
            $display("rename handshake timed out waiting for ack to rise");
        end
        req <= 1'b0;
        n = 0;
        while (ack && (n < HS_LIMIT)) begin
            @(posedge clk);
            n++;
        end
        if (ack) begin
            errors++;
            $display("rename handshake timed out waiting for ack to fall");
        end
    endtask

    task automatic rename_group(input rename_req_t g);
        predict_group(g);
        raise_req(g);
        finish_group();
    endtask

    // commits retire in program order; a later same-register lane frees the earlier lane's prd.
    task automatic commit_oldest(input int n);
        commit_bus_t bus;
        bus = '0;
        for (int k = 0; k < n; k++) begin
            bus[k]                  = in_flight.pop_front();
            exp_old[k]              = commit_map[bus[k].vrd];
            commit_map[bus[k].vrd] = bus[k].prd;
            free_q.push_back(exp_old[k]);
        end
        @(posedge clk);
        commit <= bus;
        @(posedge clk);
        commit <= '0;
    endtask

    task automatic report_test(input string name, input int err_before);
        @(posedge clk);
        @(posedge clk);
        // the pops and pushes of the test have landed, so the occupancy matches the model.
        free_count_check: assert (free_count == free_cnt_t'(free_q.size()))
            else begin
                errors++;
                $display("error free_count got %h expected %h",
                         free_count, free_cnt_t'(free_q.size()));
            end
        if (errors == err_before) begin
            passed++;
            $display("test %-16s ok", name);
        end else begin
            failed++;
            $display("test %-16s failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rename_req_t g;
        walk_bus_t   w;
        int          err_before;
        int          stalls;
        int          need;

        req        <= 1'b0;
        rename_req <= '0;
        commit     <= '0;
        walk       <= '0;
        for (int r = 0; r < ARCH_REGS; r++) begin
            spec_map[r]   = preg_t'(r);
            commit_map[r] = preg_t'(r);
        end
        for (int k = 0; k < FREE_DEPTH; k++) begin
            free_q.push_back(preg_t'(ARCH_REGS + k));
        end
        @(posedge arst_n);
        @(posedge clk);

        err_before = errors;
        rename_group(make_group(1, 2, 3, 4, 5, 6));
        report_test("reset_mapping", err_before);

        err_before = errors;
        rename_group(make_group(3, 0, 8, 8, 0, 0));
        report_test("group_bypass", err_before);

        err_before = errors;
        commit_oldest(1);
        commit_oldest(1);
        commit_oldest(1);
        report_test("single_commit", err_before);

        err_before = errors;
        rename_group(make_group(7, 1, 9, 9, 2, 9));
        commit_oldest(2);
        rename_group(make_group(9, 9, 9, 0, 0, 0));
        commit_oldest(1);
        report_test("commit_waw", err_before);

        // the walk restores x12 and x13 to their committed mappings.
        err_before = errors;
        rename_group(make_group(10, 11, 12, 12, 13, 13));
        g          = make_group(12, 13, 14, 9, 12, 0);
        w          = '0;
        w.walk     = 1'b1;
        w.we       = '1;
        w.vrd[0]   = 12;
        w.prd[0]   = commit_map[12];
        w.vrd[1]   = 13;
        w.prd[1]   = commit_map[13];
        expect_no_ack = 1'b1;
        @(posedge clk);
        walk <= w;
        raise_req(g);
        repeat (3) @(posedge clk);
        walk <= '0;
        expect_no_ack = 1'b0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            spec_map[w.vrd[k]] = w.prd[k];
        end
        // squashed registers never return since the free list has no rollback.
        in_flight.delete();
        predict_group(g);
        finish_group();
        report_test("walk", err_before);

        err_before = errors;
        stalls     = 0;
        for (int t = 0; t < RANDOM_GROUPS; t++) begin
            g    = random_group();
            need = count_needs(g);
            if (need <= free_q.size()) begin
                rename_group(g);
            end else begin
                stalls++;
                expect_no_ack = 1'b1;
                raise_req(g);
                repeat (3) @(posedge clk);
                while ((free_q.size() < need) && (in_flight.size() > 0)) begin
                    commit_oldest((in_flight.size() >= 2) ? 2 : 1);
                end
                expect_no_ack = 1'b0;
                if (free_q.size() < need) begin
                    errors++;
                    $display("nothing left to commit while the free list is short");
                    req <= 1'b0;
                    break;
                end
                predict_group(g);
                finish_group();
            end
        end
        if (stalls == 0) begin
            errors++;
            $display("random groups never exhausted the free list");
        end
        report_test("back_pressure", err_before);

        $display("tests passed %0d failed %0d", passed, failed);
        if ((failed == 0) && (errors == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // reset is released on a rising edge once the reset cycles have gone by.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule
